//--- tb.f
+incdir+include
rtl/oam_pkg.sv
rtl/oam_scan_counter.sv
rtl/oam_dma.sv
rtl/oam_bus_arbiter.sv
rtl/oam_banks.sv
rtl/oam_top.sv
test/oam_checker.sv
test/oam_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f tb.f --top-module oam_tb -o oam_sim

./obj_dir/oam_sim > sim.log 2>&1
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

//--- test/oam_tb.sv
`default_nettype none

`include "oam_macros.svh"

module oam_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import oam_pkg::*;

	localparam int PERIOD = 100;
	// rough cycle counts of the five tests
	localparam int TEST_CYCLES = 340 + 210 + 50 + 70 + 380;

	logic        clk;
	logic        rst;
	logic        cpu_rd;
	logic        cpu_wr;
	oam_addr_t   cpu_addr;
	oam_byte_t   cpu_wdata;
	logic        cpu_rvalid;
	oam_byte_t   cpu_rdata;
	logic        dma_start;
	oam_byte_t   dma_page;
	cpu_addr_t   dma_src_addr;
	logic        dma_src_rd;
	oam_byte_t   md;
	logic        dma_busy;
	logic        scan_start;
	logic        scan_valid;
	sprite_idx_t scan_idx;
	oam_byte_t   scan_y;
	oam_byte_t   scan_x;
	logic        scan_done;
	logic        render_rd;
	sprite_idx_t render_idx;
	logic        render_rvalid;
	oam_byte_t   render_tile;
	oam_byte_t   render_attr;

	logic        src_pend;
	cpu_addr_t   src_q;

	oam_top DUT (.*);

	oam_checker chk (.*);

	initial clk = 1'b0;
	always #(PERIOD / 2) clk = ~clk;

	function automatic oam_byte_t src_byte(cpu_addr_t a);
		return a[15:8] ^ (a[7:0] * 8'd37) ^ 8'h5a;
	endfunction

	// source memory answers one cycle after the read
	always @(posedge clk) begin
		src_pend <= dma_src_rd;
		src_q <= dma_src_addr;
	end

	always @(negedge clk) begin
		md <= src_pend ? src_byte(src_q) : 8'h00;
	end

	task automatic cpu_write(oam_addr_t a, oam_byte_t d);
		cpu_wr = 1'b1;
		cpu_addr = a;
		cpu_wdata = d;
		@(negedge clk);
		cpu_wr = 1'b0;
	endtask

	task automatic cpu_read(oam_addr_t a);
		cpu_rd = 1'b1;
		cpu_addr = a;
		@(negedge clk);
		cpu_rd = 1'b0;
	endtask

	task automatic render_read(sprite_idx_t i);
		render_rd = 1'b1;
		render_idx = i;
		@(negedge clk);
		render_rd = 1'b0;
	endtask

	task automatic start_dma(oam_byte_t p);
		dma_start = 1'b1;
		dma_page = p;
		@(negedge clk);
		dma_start = 1'b0;
	endtask

	task automatic start_scan();
		scan_start = 1'b1;
		@(negedge clk);
		scan_start = 1'b0;
	endtask

	task automatic read_back_all();
		for (int a = 0; a < `OAM_BYTES; a++) begin
			cpu_read(oam_addr_t'(a));
		end
		repeat (4) @(negedge clk);
	endtask

	// one random request, one cycle long
	task automatic random_op(int kinds);
		int kind;
		kind = int'($urandom % kinds);
		case (kind)
			0: cpu_write(oam_addr_t'($urandom % 200), oam_byte_t'($urandom));
			1: cpu_read(oam_addr_t'($urandom % 200));
			2: render_read(sprite_idx_t'($urandom % 48));
			3: start_dma(oam_byte_t'($urandom));
			default: start_scan();
		endcase
	endtask

	initial begin : watchdog
		#((TEST_CYCLES + 5) * PERIOD * 12 / 10);
		$display("watchdog expired before the tests finished");
		$display(">>> FAIL");
		$finish;
	end

	initial begin
		void'($urandom(32'h247e8192));
		rst = 1'b1;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		dma_start = 1'b0;
		dma_page = '0;
		md = '0;
		scan_start = 1'b0;
		render_rd = 1'b0;
		render_idx = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		start_dma(oam_byte_t'($urandom));
		while (!dma_busy) @(negedge clk);
		while (dma_busy) @(negedge clk);
		read_back_all();
		chk.end_test("dma_fill");

		repeat (200) random_op(2);
		repeat (4) @(negedge clk);
		chk.end_test("cpu_access");

		start_scan();
		while (!scan_done) @(negedge clk);
		repeat (4) @(negedge clk);
		chk.end_test("scan_sweep");

		repeat (60) render_read(sprite_idx_t'($urandom % 48));
		repeat (4) @(negedge clk);
		chk.end_test("render");

		start_dma(oam_byte_t'($urandom));
		while (dma_busy) random_op(5);
		start_scan();
		repeat (38) random_op(5);
		while (!scan_done) @(negedge clk);
		repeat (2) @(negedge clk);
		read_back_all();
		chk.end_test("contention");

		chk.report();
		if (chk.errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/oam_checker.sv
`default_nettype none

`include "oam_macros.svh"

module oam_checker (
	input logic        clk,
	input logic        rst,
	input logic        cpu_rd,
	input logic        cpu_wr,
	input logic [7:0]  cpu_addr,
	input logic [7:0]  cpu_wdata,
	input logic        cpu_rvalid,
	input logic [7:0]  cpu_rdata,
	input logic        dma_start,
	input logic [7:0]  dma_page,
	input logic [15:0] dma_src_addr,
	input logic        dma_src_rd,
	input logic [7:0]  md,
	input logic        dma_busy,
	input logic        scan_start,
	input logic        scan_valid,
	input logic [5:0]  scan_idx,
	input logic [7:0]  scan_y,
	input logic [7:0]  scan_x,
	input logic        scan_done,
	input logic        render_rd,
	input logic [5:0]  render_idx,
	input logic        render_rvalid,
	input logic [7:0]  render_tile,
	input logic [7:0]  render_attr
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0]  model [`OAM_BYTES];
	int          cpu_due [$];
	logic [7:0]  cpu_exp [$];
	int          scan_due [$];
	logic [21:0] scan_exp [$];
	int          render_due [$];
	logic [15:0] render_exp [$];

	int         cyc;
	int         errors;
	int         checks;
	int         tests;
	int         failed_tests;
	int         errors_at_start;
	int         dma_n;
	int         scan_left;
	logic       dma_on;
	logic [7:0] dma_pg;
	logic       rd_prev;
	logic [7:0] rd_prev_k;

	initial begin
		errors = 0;
		checks = 0;
		tests = 0;
		failed_tests = 0;
		errors_at_start = 0;
	end

	task automatic error_value(string msg);
		$display("Error at %0t ns: %s", $time, msg);
		errors++;
	endtask

	task automatic error_plain(string msg);
		$display("%s", msg);
		errors++;
	endtask

	task automatic end_test(string name);
		int n;
		n = errors - errors_at_start;
		tests++;
		if (n != 0) begin
			failed_tests++;
			$display("test %-12s failed with %0d errors", name, n);
		end else begin
			$display("test %-12s ok", name);
		end
		errors_at_start = errors;
	endtask

	task automatic report();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
	endtask

	always @(posedge clk) begin : watch
		logic scan_acc;
		logic scan_act;
		logic blocked;
		logic [7:0] base;
		int i;
		if (rst) begin
			cpu_due.delete();
			cpu_exp.delete();
			scan_due.delete();
			scan_exp.delete();
			render_due.delete();
			render_exp.delete();
			cyc = 0;
			dma_on = 1'b0;
			dma_n = 0;
			scan_left = 0;
			rd_prev = 1'b0;
		end else begin
			cyc++;
			// the source byte of last cycle's read lands now
			if (rd_prev) begin
				model[rd_prev_k] = md;
			end
			rd_prev = 1'b0;

			scan_acc = scan_start && scan_left == 0 && !dma_busy;
			scan_act = scan_acc || scan_left > 0;

			if (dma_busy) begin
				checks++;
				if (!dma_on) begin
					error_plain("dma_busy went high without an accepted dma_start");
				end else if (dma_n < `OAM_BYTES) begin
					if (!dma_src_rd || dma_src_addr !== {dma_pg, 8'(dma_n)}) begin
						error_value($sformatf("dma read %0d at %h, expected %h%h",
							dma_n, dma_src_addr, dma_pg, 8'(dma_n)));
					end
					rd_prev = 1'b1;
					rd_prev_k = 8'(dma_n);
				end else if (dma_src_rd) begin
					error_value("dma_src_rd high after the last source byte");
				end
				dma_n++;
			end else begin
				if (dma_src_rd) begin
					error_value("dma_src_rd high while dma_busy is low");
				end
				if (dma_on && dma_n == 0) begin
					error_plain("dma_busy did not rise after an accepted dma_start");
					dma_on = 1'b0;
				end else if (dma_on) begin
					if (dma_n != `OAM_BYTES + 1) begin
						error_value($sformatf("dma_busy lasted %0d cycles, expected 161",
							dma_n));
					end
					dma_on = 1'b0;
				end
			end
			if (dma_start && !dma_busy && !scan_act) begin
				dma_on = 1'b1;
				dma_n = 0;
				dma_pg = dma_page;
			end

			if (scan_acc) begin
				for (i = 0; i < `OAM_ENTRIES; i++) begin
					base = {i[5:0], 2'b00};
					scan_due.push_back(cyc + i + 2);
					scan_exp.push_back({i[5:0], model[base], model[base + 8'd1]});
				end
				scan_left = `OAM_ENTRIES - 1;
			end else if (scan_left > 0) begin
				scan_left--;
			end

			blocked = dma_busy || scan_act || (render_rd && render_idx < 6'd40);
			if (render_rd && !dma_busy && !scan_act && render_idx < 6'd40) begin
				render_due.push_back(cyc + 2);
				render_exp.push_back({model[{render_idx, 2'b10}], model[{render_idx, 2'b11}]});
			end
			if (cpu_rd) begin
				cpu_due.push_back(cyc + 2);
				if (blocked || cpu_addr >= 8'd160) begin
					cpu_exp.push_back(8'hff);
				end else begin
					cpu_exp.push_back(model[cpu_addr]);
				end
			end
			if (cpu_wr && !blocked && cpu_addr < 8'd160) begin
				model[cpu_addr] = cpu_wdata;
			end

			if (cpu_rvalid) begin
				checks++;
				if (cpu_due.size() == 0) begin
					error_plain("cpu_rvalid pulsed with no CPU read outstanding");
				end else if (cpu_due[0] != cyc) begin
					error_plain($sformatf("cpu_rvalid came at cycle %0d but was due at %0d",
						cyc, cpu_due[0]));
					void'(cpu_due.pop_front());
					void'(cpu_exp.pop_front());
				end else begin
					if (cpu_rdata !== cpu_exp[0]) begin
						error_value($sformatf("cpu_rdata %h, expected %h",
							cpu_rdata, cpu_exp[0]));
					end
					void'(cpu_due.pop_front());
					void'(cpu_exp.pop_front());
				end
			end else if (cpu_due.size() > 0 && cpu_due[0] <= cyc) begin
				error_plain($sformatf("cpu_rvalid missing for the read due at cycle %0d",
					cpu_due[0]));
				void'(cpu_due.pop_front());
				void'(cpu_exp.pop_front());
			end

			if (scan_done && !scan_valid) begin
				error_plain("scan_done pulsed without scan_valid");
			end
			if (scan_valid) begin
				checks++;
				if (scan_due.size() == 0 || scan_due[0] != cyc) begin
					error_plain("scan_valid arrived when no scan entry was due");
				end else begin
					if ({scan_idx, scan_y, scan_x} !== scan_exp[0]) begin
						error_value($sformatf("scan entry %0d y %h x %h, expected %h",
							scan_idx, scan_y, scan_x, scan_exp[0]));
					end
					if (scan_done !== (scan_exp[0][21:16] == 6'd39)) begin
						error_value($sformatf("scan_done %b at entry %0d",
							scan_done, scan_idx));
					end
					void'(scan_due.pop_front());
					void'(scan_exp.pop_front());
				end
			end else if (scan_due.size() > 0 && scan_due[0] <= cyc) begin
				error_plain("scan_valid missing for a scanned entry");
				void'(scan_due.pop_front());
				void'(scan_exp.pop_front());
			end

			if (render_rvalid) begin
				checks++;
				if (render_due.size() == 0 || render_due[0] != cyc) begin
					error_plain("render_rvalid arrived when no render read was due");
				end else begin
					if ({render_tile, render_attr} !== render_exp[0]) begin
						error_value($sformatf("render tile %h attr %h, expected %h",
							render_tile, render_attr, render_exp[0]));
					end
					void'(render_due.pop_front());
					void'(render_exp.pop_front());
				end
			end else if (render_due.size() > 0 && render_due[0] <= cyc) begin
				error_plain("render_rvalid missing for an accepted render read");
				void'(render_due.pop_front());
				void'(render_exp.pop_front());
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/oam_top.sv
`default_nettype none

module oam_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cpu_rd,
	input  logic                 cpu_wr,
	input  oam_pkg::oam_addr_t   cpu_addr,
	input  oam_pkg::oam_byte_t   cpu_wdata,
	output logic                 cpu_rvalid,
	output oam_pkg::oam_byte_t   cpu_rdata,
	input  logic                 dma_start,
	input  oam_pkg::oam_byte_t   dma_page,
	output oam_pkg::cpu_addr_t   dma_src_addr,
	output logic                 dma_src_rd,
	input  oam_pkg::oam_byte_t   md,
	output logic                 dma_busy,
	input  logic                 scan_start,
	output logic                 scan_valid,
	output oam_pkg::sprite_idx_t scan_idx,
	output oam_pkg::oam_byte_t   scan_y,
	output oam_pkg::oam_byte_t   scan_x,
	output logic                 scan_done,
	input  logic                 render_rd,
	input  oam_pkg::sprite_idx_t render_idx,
	output logic                 render_rvalid,
	output oam_pkg::oam_byte_t   render_tile,
	output oam_pkg::oam_byte_t   render_attr
);

	import oam_pkg::*;

	logic        scan_req;
	logic        scan_busy;
	logic        scan_last;
	sprite_idx_t scan_cnt;

	logic        dma_wr;
	oam_addr_t   dma_wr_addr;
	oam_byte_t   dma_wdata;

	oam_row_t    row;
	logic        wr_a;
	logic        wr_b;
	oam_byte_t   wdata;
	oam_byte_t   rdata_a;
	oam_byte_t   rdata_b;

	oam_scan_counter u_scan (
		.clk      (clk),
		.rst      (rst),
		.start    (scan_start),
		.dma_busy (dma_busy),
		.req      (scan_req),
		.idx      (scan_cnt),
		.busy     (scan_busy),
		.last     (scan_last)
	);

	oam_dma u_dma (
		.clk       (clk),
		.rst       (rst),
		.start     (dma_start),
		.page      (dma_page),
		.scan_busy (scan_busy),
		.src_addr  (dma_src_addr),
		.src_rd    (dma_src_rd),
		.md        (md),
		.wr        (dma_wr),
		.wr_addr   (dma_wr_addr),
		.wdata     (dma_wdata),
		.busy      (dma_busy)
	);

	oam_bus_arbiter u_arb (
		.clk           (clk),
		.rst           (rst),
		.dma_wr        (dma_wr),
		.dma_addr      (dma_wr_addr),
		.dma_wdata     (dma_wdata),
		.dma_busy      (dma_busy),
		.scan_req      (scan_req),
		.scan_idx      (scan_cnt),
		.scan_busy     (scan_busy),
		.scan_last     (scan_last),
		.render_rd     (render_rd),
		.render_idx    (render_idx),
		.cpu_rd        (cpu_rd),
		.cpu_wr        (cpu_wr),
		.cpu_addr      (cpu_addr),
		.cpu_wdata     (cpu_wdata),
		.row           (row),
		.wr_a          (wr_a),
		.wr_b          (wr_b),
		.wdata         (wdata),
		.rdata_a       (rdata_a),
		.rdata_b       (rdata_b),
		.cpu_rvalid    (cpu_rvalid),
		.cpu_rdata     (cpu_rdata),
		.scan_valid    (scan_valid),
		.scan_out_idx  (scan_idx),
		.scan_y        (scan_y),
		.scan_x        (scan_x),
		.scan_done     (scan_done),
		.render_rvalid (render_rvalid),
		.render_tile   (render_tile),
		.render_attr   (render_attr)
	);

	oam_banks u_banks (
		.clk     (clk),
		.row     (row),
		.wr_a    (wr_a),
		.wr_b    (wr_b),
		.wdata   (wdata),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b)
	);

endmodule

`default_nettype wire

//--- rtl/oam_banks.sv
`default_nettype none

`include "oam_macros.svh"

module oam_banks (
	input  logic               clk,
	input  oam_pkg::oam_row_t  row,
	input  logic               wr_a,
	input  logic               wr_b,
	input  oam_pkg::oam_byte_t wdata,
	output oam_pkg::oam_byte_t rdata_a,
	output oam_pkg::oam_byte_t rdata_b
);

	import oam_pkg::*;

	// bank 0 holds even bytes, bank 1 odd bytes
	oam_byte_t  mem [2][`OAM_ROWS];
	oam_byte_t  rd_q [2];
	logic [1:0] we;

	assign we = {wr_b, wr_a};

	// read returns the old word when the same row is written
	always_ff @(posedge clk) begin
		for (int b = 0; b < 2; b++) begin
			if (we[b]) begin
				mem[b][row] <= wdata;
			end
			rd_q[b] <= mem[b][row];
		end
	end

	assign rdata_a = rd_q[0];
	assign rdata_b = rd_q[1];

endmodule

`default_nettype wire

//--- rtl/oam_bus_arbiter.sv
`default_nettype none

`include "oam_macros.svh"

module oam_bus_arbiter (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 dma_wr,
	input  oam_pkg::oam_addr_t   dma_addr,
	input  oam_pkg::oam_byte_t   dma_wdata,
	input  logic                 dma_busy,
	input  logic                 scan_req,
	input  oam_pkg::sprite_idx_t scan_idx,
	input  logic                 scan_busy,
	input  logic                 scan_last,
	input  logic                 render_rd,
	input  oam_pkg::sprite_idx_t render_idx,
	input  logic                 cpu_rd,
	input  logic                 cpu_wr,
	input  oam_pkg::oam_addr_t   cpu_addr,
	input  oam_pkg::oam_byte_t   cpu_wdata,
	output oam_pkg::oam_row_t    row,
	output logic                 wr_a,
	output logic                 wr_b,
	output oam_pkg::oam_byte_t   wdata,
	input  oam_pkg::oam_byte_t   rdata_a,
	input  oam_pkg::oam_byte_t   rdata_b,
	output logic                 cpu_rvalid,
	output oam_pkg::oam_byte_t   cpu_rdata,
	output logic                 scan_valid,
	output oam_pkg::sprite_idx_t scan_out_idx,
	output oam_pkg::oam_byte_t   scan_y,
	output oam_pkg::oam_byte_t   scan_x,
	output logic                 scan_done,
	output logic                 render_rvalid,
	output oam_pkg::oam_byte_t   render_tile,
	output oam_pkg::oam_byte_t   render_attr
);

	import oam_pkg::*;

	oam_owner_e  owner_next, owner_q, owner_d;
	oam_row_t    row_next, row_q;
	oam_byte_t   wdata_next, wdata_q;
	logic [1:0]  we_next, we_q;
	logic        rd_next, rd_q, rd_d;
	logic        cpu_rd_q, cpu_rd_d;
	logic        sel_b_q, sel_b_d;
	logic        last_q, last_d;
	sprite_idx_t idx_q, idx_d;
	logic        cpu_ok, render_ok, cpu_hit;

	assign cpu_ok = cpu_addr < oam_addr_t'(`OAM_BYTES);

	// an out of range render request does not take the port
	assign render_ok = render_rd && (render_idx < sprite_idx_t'(`OAM_ENTRIES));

	// fixed priority: DMA, scan, render, CPU
	always_comb begin
		owner_next = OWN_IDLE;
		row_next   = cpu_addr[7:1];
		wdata_next = cpu_wdata;
		we_next    = 2'b00;
		rd_next    = 1'b0;
		if (dma_busy) begin
			owner_next = OWN_DMA;
			row_next   = dma_addr[7:1];
			wdata_next = dma_wdata;
			if (dma_wr) begin
				we_next = dma_addr[0] ? 2'b10 : 2'b01;
			end
		end else if (scan_busy) begin
			owner_next = OWN_SCAN;
			row_next   = {scan_idx, 1'b0};
			rd_next    = scan_req;
		end else if (render_ok) begin
			owner_next = OWN_RENDER;
			row_next   = {render_idx, 1'b1};
			rd_next    = 1'b1;
		end else if (cpu_rd || cpu_wr) begin
			owner_next = OWN_CPU;
			rd_next    = cpu_rd && cpu_ok;
			if (cpu_wr && cpu_ok) begin
				we_next = cpu_addr[0] ? 2'b10 : 2'b01;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			owner_q  <= OWN_IDLE;
			owner_d  <= OWN_IDLE;
			we_q     <= 2'b00;
			rd_q     <= 1'b0;
			rd_d     <= 1'b0;
			cpu_rd_q <= 1'b0;
			cpu_rd_d <= 1'b0;
		end else begin
			owner_q  <= owner_next;
			owner_d  <= owner_q;
			we_q     <= we_next;
			rd_q     <= rd_next;
			rd_d     <= rd_q;
			cpu_rd_q <= cpu_rd;
			cpu_rd_d <= cpu_rd_q;
		end
	end

	// request metadata follows the word through the bank read
	always_ff @(posedge clk) begin
		row_q   <= row_next;
		wdata_q <= wdata_next;
		sel_b_q <= cpu_addr[0];
		idx_q   <= scan_idx;
		last_q  <= scan_last;
		sel_b_d <= sel_b_q;
		idx_d   <= idx_q;
		last_d  <= last_q;
	end

	assign row   = row_q;
	assign wr_a  = we_q[0];
	assign wr_b  = we_q[1];
	assign wdata = wdata_q;

	// a CPU read always answers, with ff when blocked or out of range
	assign cpu_hit    = rd_d && (owner_d == OWN_CPU);
	assign cpu_rvalid = cpu_rd_d;
	assign cpu_rdata  = !cpu_hit ? 8'hff : (sel_b_d ? rdata_b : rdata_a);

	assign scan_valid   = rd_d && (owner_d == OWN_SCAN);
	assign scan_out_idx = idx_d;
	assign scan_y       = rdata_a;
	assign scan_x       = rdata_b;
	assign scan_done    = scan_valid && last_d;

	assign render_rvalid = rd_d && (owner_d == OWN_RENDER);
	assign render_tile   = rdata_a;
	assign render_attr   = rdata_b;

	a_one_bank: assert property (@(posedge clk) disable iff (rst)
		!(wr_a && wr_b));

endmodule

`default_nettype wire

//--- rtl/oam_dma.sv
`default_nettype none

`include "oam_macros.svh"

module oam_dma (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  oam_pkg::oam_byte_t page,
	input  logic               scan_busy,
	output oam_pkg::cpu_addr_t src_addr,
	output logic               src_rd,
	input  oam_pkg::oam_byte_t md,
	output logic               wr,
	output oam_pkg::oam_addr_t wr_addr,
	output oam_pkg::oam_byte_t wdata,
	output logic               busy
);

	import oam_pkg::*;

	logic      run;
	logic      wr_q;
	oam_addr_t cnt;
	oam_addr_t wr_addr_q;
	oam_byte_t page_q;

	// 160 read cycles, then one more for the last write
	assign src_rd   = run && (cnt != oam_addr_t'(`OAM_BYTES));
	assign src_addr = {page_q, cnt};
	assign busy     = run;

	// md arrives one cycle after src_rd
	assign wr      = wr_q;
	assign wr_addr = wr_addr_q;
	assign wdata   = md;

	always_ff @(posedge clk) begin
		if (rst) begin
			run  <= 1'b0;
			cnt  <= '0;
			wr_q <= 1'b0;
		end else begin
			wr_q <= src_rd;
			if (!run) begin
				if (start && !scan_busy) begin
					run <= 1'b1;
					cnt <= '0;
				end
			end else if (cnt == oam_addr_t'(`OAM_BYTES)) begin
				run <= 1'b0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!run && start) begin
			page_q <= page;
		end
		wr_addr_q <= cnt;
	end

	// every source read is written back next cycle, still inside the busy window
	a_rd_then_wr: assert property (@(posedge clk) disable iff (rst)
		src_rd |-> busy ##1 (wr && busy));

endmodule

`default_nettype wire

//--- rtl/oam_scan_counter.sv
`default_nettype none

`include "oam_macros.svh"

module oam_scan_counter (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  logic                 dma_busy,
	output logic                 req,
	output oam_pkg::sprite_idx_t idx,
	output logic                 busy,
	output logic                 last
);

	import oam_pkg::*;

	logic        run;
	logic        accept;
	sprite_idx_t cnt;

	// a start while DMA runs or a sweep is underway is ignored
	assign accept = start && !run && !dma_busy;

	// entry 0 goes out in the start cycle itself
	assign req  = accept || run;
	assign busy = req;
	assign idx  = cnt;
	assign last = req && (cnt == sprite_idx_t'(`OAM_ENTRIES - 1));

	// cnt sits at 0 whenever idle
	always_ff @(posedge clk) begin
		if (rst) begin
			run <= 1'b0;
			cnt <= '0;
		end else if (req) begin
			if (last) begin
				run <= 1'b0;
				cnt <= '0;
			end else begin
				run <= 1'b1;
				cnt <= cnt + 1'b1;
			end
		end
	end

	a_idx_range: assert property (@(posedge clk) disable iff (rst)
		req |-> (idx < sprite_idx_t'(`OAM_ENTRIES)));

endmodule

`default_nettype wire

//--- rtl/oam_pkg.sv
`default_nettype none

package oam_pkg;

	// byte address into OAM
	typedef logic [7:0] oam_addr_t;

	// row index, byte address without bit 0
	typedef logic [6:0] oam_row_t;

	typedef logic [7:0] oam_byte_t;

	// sprite entry number 0..39
	typedef logic [5:0] sprite_idx_t;

	// system bus address, DMA source side
	typedef logic [15:0] cpu_addr_t;

	// who drives the OAM port in a given cycle
	typedef enum logic [2:0] {
		OWN_IDLE,
		OWN_DMA,
		OWN_SCAN,
		OWN_RENDER,
		OWN_CPU
	} oam_owner_e;

endpackage

`default_nettype wire

//--- include/oam_macros.svh
`ifndef OAM_MACROS_SVH
`define OAM_MACROS_SVH

// sprite entries, 4 bytes each
`define OAM_ENTRIES 40

// total bytes, also the length of one DMA transfer
`define OAM_BYTES 160

// two-byte rows, one byte per bank
`define OAM_ROWS 80

`endif
